// ==== list.f ====
hw/cpu_pkg.sv
hw/alu.sv
hw/control_unit.sv
hw/imm_extend.sv
hw/register_file.sv
hw/hazard_unit.sv
hw/mem_sys.sv
hw/cpu_core.sv
hw/cpu_top.sv
dv/cpu_props.sv
dv/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -j 0 --top-module cpu_tb -f list.f -o cpu_tb_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/cpu_tb_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation ended abnormally"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && exit 1 || exit 0

// ==== dv/cpu_tb.sv ====
`timescale 1ns/10ps

module cpu_tb import cpu_pkg::*; ();

localparam int num_progs   = 20;
localparam int rand_len    = 180;  // Random part, the fold follows
localparam int max_len     = 200;
localparam int rst_cycles  = 8;
localparam int idle_cycles = 20;
localparam int run_cycles  = rst_cycles + max_len + idle_cycles + 3 * max_len + 40;
// A cut-short run repeats a program at most once
localparam int watchdog_cycles = 2 * num_progs * run_cycles;
localparam logic [31:0] self_loop = 32'h0000006f; // JAL x0, 0

// Instruction kinds of the random part
localparam int k_reg    = 0;
localparam int k_imm    = 1;
localparam int k_lui    = 2;
localparam int k_auipc  = 3;
localparam int k_store  = 4;
localparam int k_load   = 5;
localparam int k_branch = 6;
localparam int k_jal    = 7;
localparam int k_jlui   = 8;   // JALR group, LUI then ADDI then JALR
localparam int k_jaddi  = 9;
localparam int k_jalr   = 10;

logic            clk;
logic            rst;
logic            trigger;
logic            imem_we;
logic [7:0]      imem_addr;
logic [xlen-1:0] imem_wdata;
logic [xlen-1:0] a0;

int              seed;
int              errors;
int              checks;
int              prog_len;
int              shadow_end;  // Slots below this may be skipped by a branch
int              kind [rand_len];
logic [31:0]     prog [imem_words];
logic [31:0]     a0_exp;

cpu_top cpu_top_i (
    .clk          (clk),
    .rst          (rst),
    .trigger_i    (trigger),
    .imem_we_i    (imem_we),
    .imem_addr_i  (imem_addr),
    .imem_wdata_i (imem_wdata),
    .a0_o         (a0)
);

bind cpu_core cpu_props cpu_props_i (
    .clk       (clk),
    .rst       (rst),
    .stall_i   (stall),
    .flush_i   (flush),
    .dmem_we_i (dmem_we_o),
    .run_i     (run_q),
    .pc_i      (pc_q)
);

initial clk = 1'b0;
always #4 clk = ~clk;

function automatic int rnd(input int n);
    int v;
    v = $random(seed);
    return int'(v[30:0]) % n;
endfunction

function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                      input int f3, input int rd, input logic [6:0] op);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                      input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};
endfunction

function automatic logic [31:0] enc_b(input int off, input int rs2, input int rs1, input int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], op_branch};
endfunction

function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] op);
    return {imm[19:0], rd[4:0], op};
endfunction

function automatic logic [31:0] enc_j(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
endfunction

// Forward target that never lands inside a JALR group
function automatic int pick_target(input int i);
    int n;
    int t;
    n = (rand_len - i < 8) ? rand_len - i : 8;
    t = i + 1 + rnd(n);
    while (t < rand_len && (kind[t] == k_jaddi || kind[t] == k_jalr)) begin
        t++;
    end
    if (t > shadow_end) shadow_end = t;
    return t;
endfunction

task automatic gen_program();
    int i;
    int r;
    int rd;
    int rs1;
    int rs2;
    int f3;
    int t;
    int addr;
    int jreg;
    int last_rd;
    int stored [$];
    i = 0;
    while (i < rand_len) begin
        r = rnd(100);
        if (r < 5 && i + 3 <= rand_len) begin
            kind[i]     = k_jlui;
            kind[i + 1] = k_jaddi;
            kind[i + 2] = k_jalr;
            i += 3;
        end else begin
            if (r < 30) kind[i] = k_reg;
            else if (r < 52) kind[i] = k_imm;
            else if (r < 56) kind[i] = k_lui;
            else if (r < 60) kind[i] = k_auipc;
            else if (r < 72) kind[i] = k_store;
            else if (r < 84) kind[i] = k_load;
            else if (r < 95) kind[i] = k_branch;
            else kind[i] = k_jal;
            i++;
        end
    end
    shadow_end = 0;
    last_rd    = 1;
    jreg       = 1;
    for (i = 0; i < rand_len; i++) begin
        rd  = 1 + rnd(15);
        rs1 = (rnd(2) == 0) ? last_rd : rnd(16); // Lean on the newest result
        rs2 = (rnd(2) == 0) ? last_rd : rnd(16);
        f3  = rnd(8);
        if (kind[i] == k_load && stored.size() == 0) kind[i] = k_store;
        case (kind[i])
            k_reg: begin
                t = ((f3 == 0 || f3 == 5) && rnd(2) == 1) ? 32 : 0; // SUB, SRA
                prog[i] = enc_r(t, rs2, rs1, f3, rd, op_reg);
            end
            k_imm: begin
                if (f3 == 1) t = rnd(32);
                else if (f3 == 5) t = rnd(32) + 1024 * rnd(2);  // SRAI sets bit 10
                else t = rnd(4096);
                prog[i] = enc_i(t, rs1, f3, rd, op_imm);
            end
            k_lui:   prog[i] = enc_u(rnd(1 << 20), rd, op_lui);
            k_auipc: prog[i] = enc_u(rnd(1 << 20), rd, op_auipc);
            k_store: begin
                addr    = rnd(256);
                prog[i] = enc_s(4 * addr, rs2, 0);
                if (i >= shadow_end) stored.push_back(addr);  // Runs on every path
            end
            k_load: prog[i] = enc_i(4 * stored[rnd(stored.size())], 0, 2, rd, op_load);
            k_branch: begin
                t  = pick_target(i);
                f3 = rnd(6);
                if (f3 >= 2) f3 += 2;
                prog[i] = enc_b(4 * (t - i), rs2, rs1, f3);
            end
            k_jal: prog[i] = enc_j(4 * (pick_target(i) - i), rd);
            k_jlui: begin
                jreg    = rd;
                prog[i] = enc_u(0, jreg, op_lui);
            end
            k_jaddi: prog[i] = enc_i(4 * pick_target(i + 1), jreg, 0, jreg, op_imm);
            default: prog[i] = enc_i(0, jreg, 0, rd, op_jalr);
        endcase
        if (kind[i] == k_jlui || kind[i] == k_jaddi) last_rd = jreg;
        else if (kind[i] != k_store && kind[i] != k_branch) last_rd = rd;
    end
    // Fold x1 to x15 into a0, then park
    prog_len = rand_len;
    for (r = 1; r < 16; r++) begin
        if (r != 10) begin
            prog[prog_len] = enc_r(0, r, 10, 4, 10, op_reg);
            prog_len++;
        end
    end
    prog[prog_len] = enc_j(0, 0);
    prog_len++;
endtask

function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'd0, $signed(a) < $signed(b)};
        3'd3: return {31'd0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        default: return a >= b;
    endcase
endfunction

// Sequential instruction set model, one instruction per step
task automatic run_model(output logic [31:0] a0_out);
    logic [31:0] x [32];
    logic [31:0] mem [256];
    logic [31:0] w;
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;
    logic [31:0] u_imm;
    logic [31:0] j_imm;
    logic        wr;
    int          k;
    int          steps;
    for (k = 0; k < 32; k++) begin
        x[k] = '0;
    end
    pc    = '0;
    steps = 0;
    while (prog[pc[9:2]] != self_loop && steps < max_len) begin
        w     = prog[pc[9:2]];
        a     = x[w[19:15]];
        b     = x[w[24:20]];
        i_imm = {{20{w[31]}}, w[31:20]};
        s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
        b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        u_imm = {w[31:12], 12'd0};
        j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        npc   = pc + 32'd4;
        wr    = 1'b1;
        r     = '0;
        case (w[6:0])
            op_reg:   r = alu_model(w[14:12], w[30], a, b);
            op_imm:   r = alu_model(w[14:12], w[30] && w[14:12] == 3'd5, a, i_imm);
            op_lui:   r = u_imm;
            op_auipc: r = pc + u_imm;
            op_load: begin
                addr = a + i_imm;
                r    = mem[addr[9:2]];
            end
            op_store: begin
                addr           = a + s_imm;
                mem[addr[9:2]] = b;
                wr             = 1'b0;
            end
            op_branch: begin
                if (branch_taken(w[14:12], a, b)) npc = pc + b_imm;
                wr = 1'b0;
            end
            op_jal: begin
                r   = npc;  // Link
                npc = pc + j_imm;
            end
            op_jalr: begin
                r   = npc;
                npc = (a + i_imm) & ~32'd1;
            end
            default: wr = 1'b0;
        endcase
        if (wr && w[11:7] != 5'd0) x[w[11:7]] = r;
        pc = npc;
        steps++;
    end
    a0_out = x[10];
endtask

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error at time %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic apply_reset();
    @(posedge clk);
    rst     <= 1'b1;
    trigger <= 1'b0;
    repeat (rst_cycles) @(posedge clk);
    rst <= 1'b0;
endtask

task automatic load_program();
    int k;
    for (k = 0; k < prog_len; k++) begin
        @(posedge clk);
        imem_we    <= 1'b1;
        imem_addr  <= k[7:0];
        imem_wdata <= prog[k];
    end
    @(posedge clk);
    imem_we <= 1'b0;
endtask

// Core must stay idle with the program sitting in memory
task automatic check_idle();
    repeat (idle_cycles) begin
        @(negedge clk);
        check_value(a0, 32'd0, "a0 before trigger");
    end
endtask

task automatic start_run(input int cycles);
    @(posedge clk);
    trigger <= 1'b1;
    repeat (cycles) @(posedge clk);
endtask

initial begin
    int p;
    seed       = 95;
    errors     = 0;
    checks     = 0;
    rst        = 1'b1;
    trigger    = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    for (p = 0; p < num_progs; p++) begin
        gen_program();
        run_model(a0_exp);
        apply_reset();
        load_program();
        check_idle();
        if (p % 5 == 2) begin
            start_run(50 + rnd(300)); // Cut short, then a fresh run
            apply_reset();
            check_idle();
        end
        start_run(3 * prog_len + 20);
        @(negedge clk);
        check_value(a0, a0_exp, $sformatf("a0 of program %0d", p));
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("Done: no errors");
    end else begin
        $display("Done: errors found");
    end
    $finish;
end

initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired, the run did not finish in time");
    $display("Done: errors found");
    $finish;
end

endmodule

// ==== dv/cpu_props.sv ====
`timescale 1ns/10ps

module cpu_props import cpu_pkg::*; (
    input logic            clk,
    input logic            rst,
    input logic            stall_i,
    input logic            flush_i,
    input logic            dmem_we_i,
    input logic            run_i,
    input logic [xlen-1:0] pc_i
);

// Load-use stall and redirect come from different execute instructions
assert property (@(posedge clk) disable iff (rst) !(stall_i && flush_i))
    else $error("stall and flush set in the same cycle");

assert property (@(posedge clk) rst |-> !dmem_we_i)
    else $error("data memory write enable high during reset");

// No fetch progress before the trigger is latched
assert property (@(posedge clk) disable iff (rst) !run_i |=> $stable(pc_i))
    else $error("PC moved while the trigger was not latched");

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          trigger_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(imem_words)-1:0] imem_addr_i,  // Word address
    input  logic [xlen-1:0]               imem_wdata_i,
    output logic [xlen-1:0]               a0_o
);

logic [xlen-1:0] imem_addr;
logic [xlen-1:0] imem_rdata;
logic [xlen-1:0] dmem_addr;
logic [xlen-1:0] dmem_wdata;
logic [xlen-1:0] dmem_rdata;
logic            dmem_we;

cpu_core cpu_core_i (
    .clk          (clk),
    .rst          (rst),
    .trigger_i    (trigger_i),
    .imem_rdata_i (imem_rdata),
    .dmem_rdata_i (dmem_rdata),
    .imem_addr_o  (imem_addr),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_we_o    (dmem_we),
    .a0_o         (a0_o)
);

mem_sys mem_sys_i (
    .clk          (clk),
    .imem_we_i    (imem_we_i),
    .imem_waddr_i (imem_addr_i),
    .imem_wdata_i (imem_wdata_i),
    .imem_raddr_i (imem_addr),
    .dmem_addr_i  (dmem_addr),
    .dmem_wdata_i (dmem_wdata),
    .dmem_we_i    (dmem_we),
    .imem_rdata_o (imem_rdata),
    .dmem_rdata_o (dmem_rdata)
);

endmodule

// ==== hw/cpu_core.sv ====
`timescale 1ns/10ps

module cpu_core import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            trigger_i,
    input  logic [xlen-1:0] imem_rdata_i,
    input  logic [xlen-1:0] dmem_rdata_i,
    output logic [xlen-1:0] imem_addr_o,
    output logic [xlen-1:0] dmem_addr_o,
    output logic [xlen-1:0] dmem_wdata_o,
    output logic            dmem_we_o,
    output logic [xlen-1:0] a0_o
);

logic            run_q;          // Trigger latch
logic [xlen-1:0] pc_q;
logic            stall, flush, redirect, issue_d;
logic [1:0]      fwd_a, fwd_b;

logic            fd_valid_q;
instr_t          fd_instr_q;
logic [xlen-1:0] fd_pc_q;

logic            reg_we_d, mem_we_d, load_d, branch_d, jump_d, alu_src_b_d;
logic [2:0]      imm_src_d;
logic [1:0]      alu_src_a_d, result_src_d;
logic [3:0]      alu_op_d;
logic [xlen-1:0] imm_d, rdata1_d, rdata2_d;

logic            reg_we_e_q, mem_we_e_q, load_e_q, branch_e_q, jump_e_q;
logic            jalr_e_q, alu_src_b_e_q;
logic [1:0]      alu_src_a_e_q, result_src_e_q;
logic [3:0]      alu_op_e_q;
logic [2:0]      funct3_e_q;
logic [4:0]      rs1_e_q, rs2_e_q, rd_e_q;
logic [xlen-1:0] rdata1_e_q, rdata2_e_q, imm_e_q, pc_e_q, pc4_e_q;
logic [xlen-1:0] opnd_a, opnd_b, src_a, src_b, alu_e, target_sum, target_e;
logic            zero_e, cond_e;

logic            reg_we_m_q, mem_we_m_q, reg_we_w_q;
logic [1:0]      result_src_m_q, result_src_w_q;
logic [4:0]      rd_m_q, rd_w_q;
logic [xlen-1:0] alu_m_q, wdata_m_q, pc4_m_q, alu_w_q, load_w_q, pc4_w_q, result_w;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        run_q <= trigger_i; // Trigger held through reset starts at once
    end else if (trigger_i) begin
        run_q <= 1'b1;
    end
end

// PC and pipeline control state
always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        pc_q       <= '0;
        fd_valid_q <= 1'b0;
        reg_we_e_q <= 1'b0;
        mem_we_e_q <= 1'b0;
        load_e_q   <= 1'b0;
        branch_e_q <= 1'b0;
        jump_e_q   <= 1'b0;
        reg_we_m_q <= 1'b0;
        mem_we_m_q <= 1'b0;
        reg_we_w_q <= 1'b0;
    end else begin
        if (redirect) begin
            pc_q <= target_e;
        end else if (run_q && !stall) begin
            pc_q <= pc_q + 32'd4;
        end
        if (flush) begin
            fd_valid_q <= 1'b0; // Younger instruction in fetch dropped
        end else if (!stall) begin
            fd_valid_q <= run_q;
        end
        reg_we_e_q <= reg_we_d & issue_d;
        mem_we_e_q <= mem_we_d & issue_d;
        load_e_q   <= load_d & issue_d;
        branch_e_q <= branch_d & issue_d;
        jump_e_q   <= jump_d & issue_d;
        reg_we_m_q <= reg_we_e_q;
        mem_we_m_q <= mem_we_e_q;
        reg_we_w_q <= reg_we_m_q;
    end
end

assign issue_d = fd_valid_q & ~stall & ~flush; // Otherwise a bubble enters execute

// Stage payloads
always_ff @(posedge clk) begin
    if (!stall) begin
        fd_instr_q <= imem_rdata_i;
        fd_pc_q    <= pc_q;
    end
    alu_src_a_e_q  <= alu_src_a_d;
    alu_src_b_e_q  <= alu_src_b_d;
    alu_op_e_q     <= alu_op_d;
    result_src_e_q <= result_src_d;
    funct3_e_q     <= fd_instr_q.r.funct3;
    jalr_e_q       <= (fd_instr_q.r.opcode == op_jalr);
    rs1_e_q        <= fd_instr_q.r.rs1;
    rs2_e_q        <= fd_instr_q.r.rs2;
    rd_e_q         <= fd_instr_q.r.rd;
    rdata1_e_q     <= rdata1_d;
    rdata2_e_q     <= rdata2_d;
    imm_e_q        <= imm_d;
    pc_e_q         <= fd_pc_q;
    pc4_e_q        <= fd_pc_q + 32'd4;
    alu_m_q        <= alu_e;
    wdata_m_q      <= opnd_b;   // Store data after forwarding
    rd_m_q         <= rd_e_q;
    result_src_m_q <= result_src_e_q;
    pc4_m_q        <= pc4_e_q;
    alu_w_q        <= alu_m_q;
    load_w_q       <= dmem_rdata_i;
    rd_w_q         <= rd_m_q;
    result_src_w_q <= result_src_m_q;
    pc4_w_q        <= pc4_m_q;
end

control_unit control_unit_i (
    .instr_i      (fd_instr_q),
    .reg_we_o     (reg_we_d),
    .mem_we_o     (mem_we_d),
    .is_load_o    (load_d),
    .imm_src_o    (imm_src_d),
    .alu_src_b_o  (alu_src_b_d),
    .alu_src_a_o  (alu_src_a_d),
    .alu_op_o     (alu_op_d),
    .result_src_o (result_src_d),
    .branch_o     (branch_d),
    .jump_o       (jump_d)
);

imm_extend imm_extend_i (
    .instr_i   (fd_instr_q),
    .imm_src_i (imm_src_d),
    .imm_o     (imm_d)
);

register_file register_file_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_i    (fd_instr_q.r.rs1),
    .rs2_i    (fd_instr_q.r.rs2),
    .rd_i     (rd_w_q),
    .wdata_i  (result_w),
    .we_i     (reg_we_w_q),
    .rdata1_o (rdata1_d),
    .rdata2_o (rdata2_d),
    .a0_o     (a0_o)
);

hazard_unit hazard_unit_i (
    .rs1_d_i    (fd_instr_q.r.rs1),
    .rs2_d_i    (fd_instr_q.r.rs2),
    .rs1_e_i    (rs1_e_q),
    .rs2_e_i    (rs2_e_q),
    .rd_e_i     (rd_e_q),
    .rd_m_i     (rd_m_q),
    .rd_w_i     (rd_w_q),
    .load_e_i   (load_e_q),
    .reg_we_m_i (reg_we_m_q),
    .reg_we_w_i (reg_we_w_q),
    .redirect_i (redirect),
    .fwd_a_o    (fwd_a),
    .fwd_b_o    (fwd_b),
    .stall_o    (stall),
    .flush_o    (flush)
);

assign opnd_a = (fwd_a == fwd_mem) ? alu_m_q : (fwd_a == fwd_wb) ? result_w : rdata1_e_q;
assign opnd_b = (fwd_b == fwd_mem) ? alu_m_q : (fwd_b == fwd_wb) ? result_w : rdata2_e_q;

always_comb begin
    case (alu_src_a_e_q)
        2'd1:    src_a = pc_e_q;  // AUIPC
        2'd2:    src_a = '0;      // LUI
        default: src_a = opnd_a;
    endcase
end

assign src_b = alu_src_b_e_q ? imm_e_q : opnd_b;

alu alu_i (
    .a_i      (src_a),
    .b_i      (src_b),
    .op_i     (alu_op_e_q),
    .result_o (alu_e),
    .zero_o   (zero_e)
);

// funct3 bit 2 picks a compare over equality, bit 0 inverts
assign cond_e     = funct3_e_q[2] ? (alu_e[0] ^ funct3_e_q[0]) : (zero_e ^ funct3_e_q[0]);
assign redirect   = jump_e_q | (branch_e_q & cond_e);
assign target_sum = (jalr_e_q ? opnd_a : pc_e_q) + imm_e_q;
assign target_e   = {target_sum[xlen-1:1], target_sum[0] & ~jalr_e_q};

always_comb begin
    case (result_src_w_q)
        2'd1:    result_w = load_w_q;
        2'd2:    result_w = pc4_w_q; // Link value
        default: result_w = alu_w_q;
    endcase
end

assign imem_addr_o  = pc_q;
assign dmem_addr_o  = alu_m_q;
assign dmem_wdata_o = wdata_m_q;
assign dmem_we_o    = mem_we_m_q;

endmodule

// ==== hw/mem_sys.sv ====
`timescale 1ns/10ps

module mem_sys import cpu_pkg::*; (
    input  logic                          clk,
    input  logic                          imem_we_i,
    input  logic [$clog2(imem_words)-1:0] imem_waddr_i,
    input  logic [xlen-1:0]               imem_wdata_i,
    input  logic [xlen-1:0]               imem_raddr_i,  // Byte address
    input  logic [xlen-1:0]               dmem_addr_i,
    input  logic [xlen-1:0]               dmem_wdata_i,
    input  logic                          dmem_we_i,
    output logic [xlen-1:0]               imem_rdata_o,
    output logic [xlen-1:0]               dmem_rdata_o
);

logic [xlen-1:0] imem [imem_words];
logic [xlen-1:0] dmem [dmem_words];

always_ff @(posedge clk) begin
    if (imem_we_i) begin
        imem[imem_waddr_i] <= imem_wdata_i; // Program load port
    end
    if (dmem_we_i) begin
        dmem[dmem_addr_i[$clog2(dmem_words)+1:2]] <= dmem_wdata_i;
    end
end

// Both arrays answer in the same cycle
assign imem_rdata_o = imem[imem_raddr_i[$clog2(imem_words)+1:2]];
assign dmem_rdata_o = dmem[dmem_addr_i[$clog2(dmem_words)+1:2]];

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit import cpu_pkg::*; (
    input  logic [4:0] rs1_d_i,
    input  logic [4:0] rs2_d_i,
    input  logic [4:0] rs1_e_i,
    input  logic [4:0] rs2_e_i,
    input  logic [4:0] rd_e_i,
    input  logic [4:0] rd_m_i,
    input  logic [4:0] rd_w_i,
    input  logic       load_e_i,
    input  logic       reg_we_m_i,
    input  logic       reg_we_w_i,
    input  logic       redirect_i,
    output logic [1:0] fwd_a_o,
    output logic [1:0] fwd_b_o,
    output logic       stall_o,
    output logic       flush_o
);

// Youngest producer wins
function automatic logic [1:0] fwd_sel(input logic [4:0] rs);
    if (reg_we_m_i && rd_m_i != 5'd0 && rd_m_i == rs) begin
        return fwd_mem;
    end else if (reg_we_w_i && rd_w_i != 5'd0 && rd_w_i == rs) begin
        return fwd_wb;
    end
    return fwd_reg;
endfunction

assign fwd_a_o = fwd_sel(rs1_e_i);
assign fwd_b_o = fwd_sel(rs2_e_i);

// Load data only exists after the memory stage
assign stall_o = load_e_i && rd_e_i != 5'd0 && (rd_e_i == rs1_d_i || rd_e_i == rs2_d_i);
assign flush_o = redirect_i;

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/10ps

module register_file import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1_i,
    input  logic [4:0]      rs2_i,
    input  logic [4:0]      rd_i,
    input  logic [xlen-1:0] wdata_i,
    input  logic            we_i,
    output logic [xlen-1:0] rdata1_o,
    output logic [xlen-1:0] rdata2_o,
    output logic [xlen-1:0] a0_o
);

logic [xlen-1:0] regs [32];

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        for (int k = 0; k < 32; k++) begin
            regs[k] <= '0;
        end
    end else if (we_i && rd_i != 5'd0) begin
        regs[rd_i] <= wdata_i;
    end
end

// Same-cycle writeback passes straight through
assign rdata1_o = (rs1_i == 5'd0) ? '0 : (we_i && rs1_i == rd_i) ? wdata_i : regs[rs1_i];
assign rdata2_o = (rs2_i == 5'd0) ? '0 : (we_i && rs2_i == rd_i) ? wdata_i : regs[rs2_i];
assign a0_o     = regs[10];

endmodule

// ==== hw/imm_extend.sv ====
`timescale 1ns/10ps

module imm_extend import cpu_pkg::*; (
    input  instr_t          instr_i,
    input  logic [2:0]      imm_src_i,
    output logic [xlen-1:0] imm_o
);

logic [24:0] f; // Instruction bits 31 to 7, so f[k] is bit k+7

assign f = instr_i.im.imm;

always_comb begin
    case (imm_src_i)
        imm_s:   imm_o = {{20{f[24]}}, f[24:18], f[4:0]};
        imm_b:   imm_o = {{19{f[24]}}, f[24], f[0], f[23:18], f[4:1], 1'b0};
        imm_u:   imm_o = {f[24:5], 12'b0};
        imm_j:   imm_o = {{11{f[24]}}, f[24], f[12:5], f[13], f[23:14], 1'b0};
        default: imm_o = {{20{f[24]}}, f[24:13]}; // I format
    endcase
end

endmodule

// ==== hw/control_unit.sv ====
`timescale 1ns/10ps

module control_unit import cpu_pkg::*; (
    input  instr_t     instr_i,
    output logic       reg_we_o,
    output logic       mem_we_o,
    output logic       is_load_o,
    output logic [2:0] imm_src_o,
    output logic       alu_src_b_o,
    output logic [1:0] alu_src_a_o,   // 0 register, 1 PC, 2 zero
    output logic [3:0] alu_op_o,
    output logic [1:0] result_src_o,  // 0 ALU, 1 load, 2 PC plus 4
    output logic       branch_o,
    output logic       jump_o
);

logic [3:0] alu_fn;
logic       alt;

assign alt = instr_i.r.funct7[5]; // SUB and SRA flag

always_comb begin
    case (instr_i.r.funct3)
        3'b000: alu_fn = alu_add;
        3'b001: alu_fn = alu_sll;
        3'b010: alu_fn = alu_slt;
        3'b011: alu_fn = alu_sltu;
        3'b100: alu_fn = alu_xor;
        3'b101: alu_fn = alt ? alu_sra : alu_srl;
        3'b110: alu_fn = alu_or;
        3'b111: alu_fn = alu_and;
    endcase
end

always_comb begin
    reg_we_o     = 1'b0;
    mem_we_o     = 1'b0;
    is_load_o    = 1'b0;
    imm_src_o    = imm_i;
    alu_src_b_o  = 1'b1;
    alu_src_a_o  = 2'd0;
    alu_op_o     = alu_add;
    result_src_o = 2'd0;
    branch_o     = 1'b0;
    jump_o       = 1'b0;
    case (instr_i.r.opcode)
        op_reg: begin
            reg_we_o    = 1'b1;
            alu_src_b_o = 1'b0;
            alu_op_o    = (instr_i.r.funct3 == 3'b000 && alt) ? alu_sub : alu_fn;
        end
        op_imm: begin
            reg_we_o = 1'b1;
            alu_op_o = alu_fn;
        end
        op_lui: begin
            reg_we_o    = 1'b1;
            imm_src_o   = imm_u;
            alu_src_a_o = 2'd2;
            alu_op_o    = alu_pass_b;
        end
        op_auipc: begin
            reg_we_o    = 1'b1;
            imm_src_o   = imm_u;
            alu_src_a_o = 2'd1;
        end
        op_load: begin
            reg_we_o     = 1'b1;
            is_load_o    = 1'b1;
            result_src_o = 2'd1;
        end
        op_store: begin
            mem_we_o  = 1'b1;
            imm_src_o = imm_s;
        end
        op_branch: begin
            branch_o    = 1'b1;
            imm_src_o   = imm_b;
            alu_src_b_o = 1'b0;
            case (instr_i.r.funct3[2:1])
                2'b10:   alu_op_o = alu_slt;   // BLT, BGE
                2'b11:   alu_op_o = alu_sltu;  // BLTU, BGEU
                default: alu_op_o = alu_sub;   // BEQ, BNE
            endcase
        end
        op_jal, op_jalr: begin
            reg_we_o     = 1'b1;
            jump_o       = 1'b1;
            imm_src_o    = (instr_i.r.opcode == op_jal) ? imm_j : imm_i;
            result_src_o = 2'd2;
        end
        default: ; // Unknown opcode acts as a no-op
    endcase
end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/10ps

module alu import cpu_pkg::*; (
    input  logic [xlen-1:0] a_i,
    input  logic [xlen-1:0] b_i,
    input  logic [3:0]      op_i,
    output logic [xlen-1:0] result_o,
    output logic            zero_o
);

logic [4:0] shamt;

assign shamt = b_i[4:0];

always_comb begin
    case (op_i)
        alu_add:    result_o = a_i + b_i;
        alu_sub:    result_o = a_i - b_i;
        alu_sll:    result_o = a_i << shamt;
        alu_slt:    result_o = xlen'($signed(a_i) < $signed(b_i));
        alu_sltu:   result_o = xlen'(a_i < b_i);
        alu_xor:    result_o = a_i ^ b_i;
        alu_srl:    result_o = a_i >> shamt;
        alu_sra:    result_o = $signed(a_i) >>> shamt;
        alu_or:     result_o = a_i | b_i;
        alu_and:    result_o = a_i & b_i;
        alu_pass_b: result_o = b_i;
        default:    result_o = '0;
    endcase
end

assign zero_o = (result_o == '0); // Equality test for BEQ and BNE

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

localparam int xlen = 32; // Data and address width

// Major opcodes
localparam logic [6:0] op_lui    = 7'b0110111;
localparam logic [6:0] op_auipc  = 7'b0010111;
localparam logic [6:0] op_jal    = 7'b1101111;
localparam logic [6:0] op_jalr   = 7'b1100111;
localparam logic [6:0] op_branch = 7'b1100011;
localparam logic [6:0] op_load   = 7'b0000011;
localparam logic [6:0] op_store  = 7'b0100011;
localparam logic [6:0] op_imm    = 7'b0010011;
localparam logic [6:0] op_reg    = 7'b0110011;

// ALU operation codes
localparam logic [3:0] alu_add    = 4'd0;
localparam logic [3:0] alu_sub    = 4'd1;
localparam logic [3:0] alu_sll    = 4'd2;
localparam logic [3:0] alu_slt    = 4'd3;
localparam logic [3:0] alu_sltu   = 4'd4;
localparam logic [3:0] alu_xor    = 4'd5;
localparam logic [3:0] alu_srl    = 4'd6;
localparam logic [3:0] alu_sra    = 4'd7;
localparam logic [3:0] alu_or     = 4'd8;
localparam logic [3:0] alu_and    = 4'd9;
localparam logic [3:0] alu_pass_b = 4'd10;

// Immediate formats
localparam logic [2:0] imm_i = 3'd0;
localparam logic [2:0] imm_s = 3'd1;
localparam logic [2:0] imm_b = 3'd2;
localparam logic [2:0] imm_u = 3'd3;
localparam logic [2:0] imm_j = 3'd4;

// Forwarding selects for the execute operands
localparam logic [1:0] fwd_reg = 2'd0;
localparam logic [1:0] fwd_wb  = 2'd1;
localparam logic [1:0] fwd_mem = 2'd2;

localparam int imem_words = 256;
localparam int dmem_words = 256;

// One instruction word, seen as register fields or as immediate bits
typedef union packed {
    struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r;
    struct packed {
        logic [24:0] imm;    // Instruction bits 31 to 7
        logic [6:0]  opcode;
    } im;
} instr_t;

endpackage
